/* hdl/fll.sv */
`timescale 1ns/1ps

module fll
   import fll_types_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      i_start,
   input  tag_t      i_tag,
   input  iq_t       i_iq_prompt_k,
   input  iq_t       i_iq_prompt_km1,
   input  acc_t      i_i_prompt_k,
   input  acc_t      i_q_prompt_k,
   input  acc_t      i_i_prompt_km1,
   input  acc_t      i_q_prompt_km1,
   input  w_df_t     i_w_df_k,
   input  w_df_dot_t i_w_df_dot_k,
   output logic      o_starting,
   output logic      o_result_ready,
   output tag_t      o_result_tag,
   output inc_t      o_doppler_inc_kp1,
   output w_df_t     o_w_df_kp1,
   output w_df_dot_t o_w_df_dot_kp1
);

   logic idle;
   logic start_ok;
   logic operands_valid;
   op_t  op_iq_k;
   op_t  op_iq_km1;
   op_t  op_i_k;
   op_t  op_q_k;
   op_t  op_i_km1;
   op_t  op_q_km1;
   logic div_start;
   num_t num_abs;
   logic num_sign;
   den_t den;
   logic dtheta_valid;
   quo_t dtheta;

   // One update in flight, a start while busy is dropped.
   assign start_ok = i_start && idle;

   always_ff @(posedge clk) begin
      if (reset) begin
         idle <= 1'b1;
      end else if (o_result_ready) begin
         idle <= 1'b1;
      end else if (start_ok) begin
         idle <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (start_ok) begin
         o_result_tag <= i_tag;
      end
   end

   fll_operand_trunc u_trunc (
      .clk(clk), .reset(reset), .i_start(start_ok),
      .i_iq_k(i_iq_prompt_k), .i_iq_km1(i_iq_prompt_km1),
      .i_i_k(i_i_prompt_k), .i_q_k(i_q_prompt_k),
      .i_i_km1(i_i_prompt_km1), .i_q_km1(i_q_prompt_km1),
      .o_starting(o_starting), .o_operands_valid(operands_valid),
      .o_iq_k(op_iq_k), .o_iq_km1(op_iq_km1), .o_i_k(op_i_k),
      .o_q_k(op_q_k), .o_i_km1(op_i_km1), .o_q_km1(op_q_km1)
   );

   fll_discriminator u_disc (
      .clk(clk), .reset(reset), .i_operands_valid(operands_valid),
      .i_iq_k(op_iq_k), .i_iq_km1(op_iq_km1), .i_i_k(op_i_k),
      .i_q_k(op_q_k), .i_i_km1(op_i_km1), .i_q_km1(op_q_km1),
      .o_div_start(div_start), .o_num_abs(num_abs),
      .o_num_sign(num_sign), .o_den(den)
   );

   fll_angle_divider u_div (
      .clk(clk), .reset(reset), .i_div_start(div_start),
      .i_num_abs(num_abs), .i_den(den),
      .o_dtheta_valid(dtheta_valid), .o_dtheta(dtheta)
   );

   fll_loop_update u_update (
      .clk(clk), .reset(reset), .i_dtheta_valid(dtheta_valid),
      .i_dtheta(dtheta), .i_dtheta_sign(num_sign),
      .i_w_df_k(i_w_df_k), .i_w_df_dot_k(i_w_df_dot_k),
      .o_result_ready(o_result_ready), .o_w_df_kp1(o_w_df_kp1),
      .o_w_df_dot_kp1(o_w_df_dot_kp1), .o_doppler_inc_kp1(o_doppler_inc_kp1)
   );

endmodule

/* hdl/fll_angle_divider.sv */
`timescale 1ns/1ps
`include "fll_config.svh"

module fll_angle_divider
   import fll_types_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic i_div_start,
   input  num_t i_num_abs,
   input  den_t i_den,
   output logic o_dtheta_valid,
   output quo_t o_dtheta
);

   localparam int NUM_W = $bits(num_t);
   localparam int SH_W  = $bits(den_t) + `FLL_QUO_WIDTH - 1;

   logic                            busy;
   logic [`FLL_DIV_COUNT_WIDTH-1:0] count;
   logic [NUM_W-1:0]                rem;
   logic [SH_W-1:0]                 div_sh;
   quo_t                            quo_acc;
   logic                            den_zero;
   logic                            q_bit;
   logic [NUM_W-1:0]                rem_next;

   // Trial subtraction of the divisor aligned to the current bit.
   assign q_bit    = {{(SH_W-NUM_W){1'b0}}, rem} >= div_sh;
   assign rem_next = q_bit ? rem - div_sh[NUM_W-1:0] : rem;

   always_ff @(posedge clk) begin
      if (reset) begin
         busy           <= 1'b0;
         o_dtheta_valid <= 1'b0;
      end else begin
         o_dtheta_valid <= busy && (count == '0);
         if (i_div_start) begin
            busy <= 1'b1;
         end else if (count == '0) begin
            busy <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_div_start) begin
         rem      <= i_num_abs;
         div_sh   <= {i_den, {(`FLL_QUO_WIDTH-1){1'b0}}};
         count    <= `FLL_DIV_COUNT_WIDTH'(`FLL_QUO_WIDTH - 1);
         quo_acc  <= '0;
         den_zero <= (i_den == '0);
      end else if (busy) begin
         rem     <= rem_next;
         div_sh  <= div_sh >> 1;
         count   <= count - 1'b1;
         quo_acc <= {quo_acc[`FLL_QUO_WIDTH-2:0], q_bit};
         // Last bit, the angle is zero for a zero divisor.
         if (count == '0) begin
            o_dtheta <= den_zero ? '0 : {quo_acc[`FLL_QUO_WIDTH-2:0], q_bit};
         end
      end
   end

endmodule

/* hdl/fll_config.svh */
`ifndef FLL_CONFIG_SVH
`define FLL_CONFIG_SVH

// Correlator history widths.
`define FLL_IQ_WIDTH 18
`define FLL_ACC_WIDTH 19

// Smart truncation and angle division.
`define FLL_OP_WIDTH 12
`define FLL_SHIFT_WIDTH 5
`define FLL_ANGLE_SHIFT 8
`define FLL_QUO_WIDTH 16
`define FLL_DIV_COUNT_WIDTH 4

// Loop state widths.
`define FLL_W_DF_WIDTH 24
`define FLL_W_DF_DOT_WIDTH 20
`define FLL_INC_WIDTH 28

// Loop constants, all unsigned.
`define FLL_CONST_WIDTH 12
`define FLL_A 12'd410
`define FLL_B 12'd1843
`define FLL_T 12'd1000
`define FLL_W_DF_TO_INC 12'd2851

// Right shifts after each constant product.
`define FLL_CONST_SHIFT 10
`define FLL_PER_SHIFT 10
`define FLL_INC_SHIFT 4

// Channel tag.
`define FLL_TAG_WIDTH 6

// Accepted start to o_starting, in clk cycles.
`define FLL_STARTING_DELAY 5

`endif

/* hdl/fll_ctrl_pkg.sv */
package fll_ctrl_pkg;

   // Smart truncation sequencer.
   typedef enum logic [2:0] {
      TRUNC_IDLE, TRUNC_ENC, TRUNC_IQ, TRUNC_K, TRUNC_KM1, TRUNC_DONE
   } trunc_state_t;

   // Numerator/denominator sequencer.
   typedef enum logic [2:0] {
      DISC_IDLE, DISC_MULT_0, DISC_MULT_1, DISC_MULT_2,
      DISC_MULT_3, DISC_MULT_4, DISC_MULT_5
   } disc_state_t;

   // Loop update sequencer.
   typedef enum logic [3:0] {
      UPD_IDLE, UPD_W_DF_0, UPD_W_DF_1, UPD_W_DF_2, UPD_W_DF_DOT_0,
      UPD_W_DF_DOT_1, UPD_INC_0, UPD_INC_1, UPD_DONE
   } update_state_t;

endpackage

/* hdl/fll_discriminator.sv */
`timescale 1ns/1ps
`include "fll_config.svh"

module fll_discriminator
   import fll_types_pkg::*;
   import fll_ctrl_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic i_operands_valid,
   input  op_t  i_iq_k,
   input  op_t  i_iq_km1,
   input  op_t  i_i_k,
   input  op_t  i_q_k,
   input  op_t  i_i_km1,
   input  op_t  i_q_km1,
   output logic o_div_start,
   output num_t o_num_abs,
   output logic o_num_sign,
   output den_t o_den
);

   localparam int NUM_MSB = $bits(num_t) - 1;

   disc_state_t                      state;
   op_t                              mult_a;
   op_t                              mult_b;
   logic signed [2*`FLL_OP_WIDTH-1:0] mult_p;
   num_t                             num_acc;

   // Shared multiplier, registered operands and product.
   // A product is read two states after its operands are loaded.
   always_ff @(posedge clk) begin
      mult_p <= mult_a * mult_b;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= DISC_IDLE;
         o_div_start <= 1'b0;
      end else begin
         o_div_start <= (state == DISC_MULT_5);
         case (state)
            DISC_IDLE:   state <= i_operands_valid ? DISC_MULT_0 : DISC_IDLE;
            DISC_MULT_0: state <= DISC_MULT_1;
            DISC_MULT_1: state <= DISC_MULT_2;
            DISC_MULT_2: state <= DISC_MULT_3;
            DISC_MULT_3: state <= DISC_MULT_4;
            DISC_MULT_4: state <= DISC_MULT_5;
            default:     state <= DISC_IDLE;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Numerator Q_k*I_km1 - I_k*Q_km1, denominator IQ_k*IQ_km1
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      case (state)
         DISC_MULT_0: begin
            mult_a <= i_q_k;
            mult_b <= i_i_km1;
         end
         DISC_MULT_1: begin
            mult_a <= i_i_k;
            mult_b <= i_q_km1;
         end
         DISC_MULT_2: begin
            mult_a  <= i_iq_k;
            mult_b  <= i_iq_km1;
            num_acc <= num_t'(mult_p) <<< `FLL_ANGLE_SHIFT;
         end
         DISC_MULT_3: begin
            num_acc <= num_acc - (num_t'(mult_p) <<< `FLL_ANGLE_SHIFT);
         end
         // Both magnitudes are non-negative.
         DISC_MULT_4: o_den <= den_t'(mult_p);
         DISC_MULT_5: begin
            o_num_sign <= num_acc[NUM_MSB];
            o_num_abs  <= num_acc[NUM_MSB] ? -num_acc : num_acc;
         end
         default: ;
      endcase
   end

endmodule

/* hdl/fll_loop_update.sv */
`timescale 1ns/1ps
`include "fll_config.svh"

module fll_loop_update
   import fll_types_pkg::*;
   import fll_ctrl_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      i_dtheta_valid,
   input  quo_t      i_dtheta,
   input  logic      i_dtheta_sign,
   input  w_df_t     i_w_df_k,
   input  w_df_dot_t i_w_df_dot_k,
   output logic      o_result_ready,
   output w_df_t     o_w_df_kp1,
   output w_df_dot_t o_w_df_dot_kp1,
   output inc_t      o_doppler_inc_kp1
);

   localparam int B_W = `FLL_W_DF_WIDTH;

   update_state_t                           state;
   quo_t                                    dtheta_q;
   logic                                    dtheta_sign_q;
   logic [`FLL_CONST_WIDTH-1:0]             mult_a;
   logic [B_W-1:0]                          mult_b;
   logic [`FLL_CONST_WIDTH+B_W-1:0]         mult_p;
   logic [`FLL_W_DF_DOT_WIDTH-1:0]          w_df_dot_abs;
   logic [B_W-1:0]                          w_df_abs;
   w_df_t                                   w_df_acc;
   w_df_dot_t                               w_df_dot_acc;
   w_df_t                                   per_term;
   w_df_t                                   b_term;
   w_df_dot_t                               a_term;
   inc_t                                    inc_term;

   assign w_df_dot_abs = i_w_df_dot_k[`FLL_W_DF_DOT_WIDTH-1] ? -i_w_df_dot_k : i_w_df_dot_k;
   assign w_df_abs     = w_df_acc[B_W-1] ? -w_df_acc : w_df_acc;

   // Shifted magnitudes, cut to the width of their target.
   assign per_term = w_df_t'(mult_p >> `FLL_PER_SHIFT);
   assign b_term   = w_df_t'(mult_p >> `FLL_CONST_SHIFT);
   assign a_term   = w_df_dot_t'(mult_p >> `FLL_CONST_SHIFT);
   assign inc_term = inc_t'(mult_p >> `FLL_INC_SHIFT);

   // Unsigned constant multiplier, two cycles from operands to product.
   always_ff @(posedge clk) begin
      mult_p <= mult_a * mult_b;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= UPD_IDLE;
      end else begin
         case (state)
            UPD_IDLE:       state <= i_dtheta_valid ? UPD_W_DF_0 : UPD_IDLE;
            UPD_W_DF_0:     state <= UPD_W_DF_1;
            UPD_W_DF_1:     state <= UPD_W_DF_2;
            UPD_W_DF_2:     state <= UPD_W_DF_DOT_0;
            UPD_W_DF_DOT_0: state <= UPD_W_DF_DOT_1;
            UPD_W_DF_DOT_1: state <= UPD_INC_0;
            UPD_INC_0:      state <= UPD_INC_1;
            UPD_INC_1:      state <= UPD_DONE;
            default:        state <= UPD_IDLE;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Sign-magnitude steps of the second-order loop
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      case (state)
         UPD_IDLE: begin
            dtheta_q      <= i_dtheta;
            dtheta_sign_q <= i_dtheta_sign;
         end
         UPD_W_DF_0: begin
            mult_a <= `FLL_T;
            mult_b <= {{(B_W-`FLL_W_DF_DOT_WIDTH){1'b0}}, w_df_dot_abs};
         end
         UPD_W_DF_1: begin
            mult_a <= `FLL_B;
            mult_b <= {{(B_W-`FLL_QUO_WIDTH){1'b0}}, dtheta_q};
         end
         UPD_W_DF_2: begin
            mult_a   <= `FLL_A;
            mult_b   <= {{(B_W-`FLL_QUO_WIDTH){1'b0}}, dtheta_q};
            w_df_acc <= i_w_df_dot_k[`FLL_W_DF_DOT_WIDTH-1] ?
                        i_w_df_k - per_term : i_w_df_k + per_term;
         end
         UPD_W_DF_DOT_0: begin
            w_df_acc <= dtheta_sign_q ? w_df_acc - b_term : w_df_acc + b_term;
         end
         // Frequency is final here, start the increment conversion.
         UPD_W_DF_DOT_1: begin
            mult_a       <= `FLL_W_DF_TO_INC;
            mult_b       <= w_df_abs;
            w_df_dot_acc <= dtheta_sign_q ? i_w_df_dot_k - a_term : i_w_df_dot_k + a_term;
         end
         UPD_INC_1: begin
            o_w_df_kp1        <= w_df_acc;
            o_w_df_dot_kp1    <= w_df_dot_acc;
            o_doppler_inc_kp1 <= w_df_acc[B_W-1] ? -inc_term : inc_term;
         end
         default: ;
      endcase
   end

   assign o_result_ready = (state == UPD_DONE);

endmodule

/* hdl/fll_operand_trunc.sv */
`timescale 1ns/1ps
`include "fll_config.svh"

module fll_operand_trunc
   import fll_types_pkg::*;
   import fll_ctrl_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic i_start,
   input  iq_t  i_iq_k,
   input  iq_t  i_iq_km1,
   input  acc_t i_i_k,
   input  acc_t i_q_k,
   input  acc_t i_i_km1,
   input  acc_t i_q_km1,
   output logic o_starting,
   output logic o_operands_valid,
   output op_t  o_iq_k,
   output op_t  o_iq_km1,
   output op_t  o_i_k,
   output op_t  o_q_k,
   output op_t  o_i_km1,
   output op_t  o_q_km1
);

   // Keep the bits just below the MSB, sign-extended by the shift.
   function automatic op_t trunc_op(input acc_t value, input shift_t shift);
      acc_t shifted;
      shifted = value >>> shift;
      return shifted[`FLL_OP_WIDTH-1:0];
   endfunction

   trunc_state_t state;
   iq_t          iq_max;
   shift_t       msb_idx;
   shift_t       shift_next;
   shift_t       shift_q;
   acc_t         trunc0_in;
   acc_t         trunc1_in;
   op_t          trunc0_out;
   op_t          trunc1_out;

   //////////////////////////////////////////////////////////////////////
   // Priority encode of the larger magnitude
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      iq_max = (i_iq_k > i_iq_km1) ? i_iq_k : i_iq_km1;
      msb_idx = '0;
      for (int b = 0; b < `FLL_IQ_WIDTH; b++) begin
         if (iq_max[b]) begin
            msb_idx = shift_t'(b);
         end
      end
   end

   // Leave one spare bit above the MSB for the sign.
   assign shift_next = (int'(msb_idx) + 2 > `FLL_OP_WIDTH) ?
                       shift_t'(int'(msb_idx) + 2 - `FLL_OP_WIDTH) : '0;

   //////////////////////////////////////////////////////////////////////
   // Two shared truncators, stepped by pairs
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      case (state)
         TRUNC_K: begin
            trunc0_in = i_i_k;
            trunc1_in = i_q_k;
         end
         TRUNC_KM1: begin
            trunc0_in = i_i_km1;
            trunc1_in = i_q_km1;
         end
         // Magnitudes are unsigned, so zero-extend.
         default: begin
            trunc0_in = acc_t'({1'b0, i_iq_k});
            trunc1_in = acc_t'({1'b0, i_iq_km1});
         end
      endcase
   end

   assign trunc0_out = trunc_op(trunc0_in, shift_q);
   assign trunc1_out = trunc_op(trunc1_in, shift_q);

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= TRUNC_IDLE;
      end else begin
         case (state)
            TRUNC_IDLE: state <= i_start ? TRUNC_ENC : TRUNC_IDLE;
            TRUNC_ENC:  state <= TRUNC_IQ;
            TRUNC_IQ:   state <= TRUNC_K;
            TRUNC_K:    state <= TRUNC_KM1;
            TRUNC_KM1:  state <= TRUNC_DONE;
            default:    state <= TRUNC_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      case (state)
         TRUNC_ENC: shift_q <= shift_next;
         TRUNC_IQ: begin
            o_iq_k   <= trunc0_out;
            o_iq_km1 <= trunc1_out;
         end
         TRUNC_K: begin
            o_i_k <= trunc0_out;
            o_q_k <= trunc1_out;
         end
         TRUNC_KM1: begin
            o_i_km1 <= trunc0_out;
            o_q_km1 <= trunc1_out;
         end
         default: ;
      endcase
   end

   // Inputs are no longer read once all three pairs are stored.
   assign o_operands_valid = (state == TRUNC_DONE);
   assign o_starting       = (state == TRUNC_DONE);

endmodule

/* hdl/fll_types_pkg.sv */
`include "fll_config.svh"

package fll_types_pkg;

   // Prompt correlator history.
   typedef logic [`FLL_IQ_WIDTH-1:0] iq_t;
   typedef logic signed [`FLL_ACC_WIDTH-1:0] acc_t;

   // Truncated operands and shift amount.
   typedef logic signed [`FLL_OP_WIDTH-1:0] op_t;
   typedef logic [`FLL_SHIFT_WIDTH-1:0] shift_t;

   // Division operands and result.
   // Numerator carries a sign bit plus the angle shift.
   typedef logic signed [2*`FLL_OP_WIDTH+`FLL_ANGLE_SHIFT:0] num_t;
   typedef logic [2*`FLL_OP_WIDTH-1:0] den_t;
   typedef logic [`FLL_QUO_WIDTH-1:0] quo_t;

   // Loop state.
   typedef logic signed [`FLL_W_DF_WIDTH-1:0] w_df_t;
   typedef logic signed [`FLL_W_DF_DOT_WIDTH-1:0] w_df_dot_t;
   typedef logic signed [`FLL_INC_WIDTH-1:0] inc_t;

   // Channel tag.
   typedef logic [`FLL_TAG_WIDTH-1:0] tag_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the FLL testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module fll_tb -o fll_tb_sim

# A $fatal in the testbench gives a nonzero exit status.
./obj_dir/fll_tb_sim

/* src.f */
+incdir+hdl
hdl/fll_types_pkg.sv
hdl/fll_ctrl_pkg.sv
hdl/fll_operand_trunc.sv
hdl/fll_discriminator.sv
hdl/fll_angle_divider.sv
hdl/fll_loop_update.sv
hdl/fll.sv
verification/fll_tb.sv

/* verification/fll_tb.sv */
`timescale 1ns/1ps
`include "fll_config.svh"

module fll_tb
   import fll_types_pkg::*;
();

   // Longest wait for any strobe in clk cycles.
   localparam int WAIT_LIMIT = 200;

   logic      clk;
   logic      reset;
   logic      i_start;
   tag_t      i_tag;
   iq_t       i_iq_prompt_k;
   iq_t       i_iq_prompt_km1;
   acc_t      i_i_prompt_k;
   acc_t      i_q_prompt_k;
   acc_t      i_i_prompt_km1;
   acc_t      i_q_prompt_km1;
   w_df_t     i_w_df_k;
   w_df_dot_t i_w_df_dot_k;
   logic      o_starting;
   logic      o_result_ready;
   tag_t      o_result_tag;
   inc_t      o_doppler_inc_kp1;
   w_df_t     o_w_df_kp1;
   w_df_dot_t o_w_df_dot_kp1;

   // Stimulus vector of the current update.
   iq_t       vec_iq_k;
   iq_t       vec_iq_km1;
   acc_t      vec_i_k;
   acc_t      vec_q_k;
   acc_t      vec_i_km1;
   acc_t      vec_q_km1;
   w_df_t     vec_w_df;
   w_df_dot_t vec_w_df_dot;

   logic [15:0] lfsr_state;

   fll UUT (
      .clk(clk), .reset(reset), .i_start(i_start), .i_tag(i_tag),
      .i_iq_prompt_k(i_iq_prompt_k), .i_iq_prompt_km1(i_iq_prompt_km1),
      .i_i_prompt_k(i_i_prompt_k), .i_q_prompt_k(i_q_prompt_k),
      .i_i_prompt_km1(i_i_prompt_km1), .i_q_prompt_km1(i_q_prompt_km1),
      .i_w_df_k(i_w_df_k), .i_w_df_dot_k(i_w_df_dot_k),
      .o_starting(o_starting), .o_result_ready(o_result_ready),
      .o_result_tag(o_result_tag), .o_doppler_inc_kp1(o_doppler_inc_kp1),
      .o_w_df_kp1(o_w_df_kp1), .o_w_df_dot_kp1(o_w_df_dot_kp1)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Random bits and reference model
   //////////////////////////////////////////////////////////////////////

   // Taps 16, 14, 13, 11.
   function automatic logic [15:0] lfsr_next(input logic [15:0] state);
      logic feedback;
      feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
      return {state[14:0], feedback};
   endfunction

   function automatic logic [31:0] draw_bits(input int count);
      logic [31:0] value;
      value = '0;
      for (int k = 0; k < count; k++) begin
         lfsr_state = lfsr_next(lfsr_state);
         value = {value[30:0], lfsr_state[0]};
      end
      return value;
   endfunction

   // Max plus half min is never below the true norm.
   function automatic iq_t magnitude_estimate(input acc_t i_val, input acc_t q_val);
      longint a;
      longint b;
      a = (i_val < 0) ? -longint'(i_val) : longint'(i_val);
      b = (q_val < 0) ? -longint'(q_val) : longint'(q_val);
      return (a > b) ? iq_t'(a + b / 2) : iq_t'(b + a / 2);
   endfunction

   function automatic void model_update(output w_df_t exp_w_df,
                                        output w_df_dot_t exp_w_df_dot,
                                        output inc_t exp_inc);
      iq_t    big;
      int     msb;
      int     sh;
      longint t_iq_k;
      longint t_iq_km1;
      longint t_i_k;
      longint t_q_k;
      longint t_i_km1;
      longint t_q_km1;
      longint num;
      longint den;
      longint dtheta;
      longint dot_mag;
      longint w_mag;
      longint term;
      big = (vec_iq_k > vec_iq_km1) ? vec_iq_k : vec_iq_km1;
      msb = 0;
      for (int b = 0; b < `FLL_IQ_WIDTH; b++) begin
         if (big[b]) begin
            msb = b;
         end
      end
      sh = msb + 2 - `FLL_OP_WIDTH;
      if (sh < 0) begin
         sh = 0;
      end
      t_iq_k   = longint'(vec_iq_k) >>> sh;
      t_iq_km1 = longint'(vec_iq_km1) >>> sh;
      t_i_k    = longint'(vec_i_k) >>> sh;
      t_q_k    = longint'(vec_q_k) >>> sh;
      t_i_km1  = longint'(vec_i_km1) >>> sh;
      t_q_km1  = longint'(vec_q_km1) >>> sh;
      num = (t_q_k * t_i_km1 - t_i_k * t_q_km1) * (longint'(1) << `FLL_ANGLE_SHIFT);
      den = t_iq_k * t_iq_km1;
      dtheta = (den == 0) ? 0 : ((num < 0) ? -num : num) / den;
      // Period term follows the sign of the rate.
      dot_mag = (vec_w_df_dot < 0) ? -longint'(vec_w_df_dot) : longint'(vec_w_df_dot);
      term = (dot_mag * `FLL_T) >> `FLL_PER_SHIFT;
      exp_w_df = (vec_w_df_dot < 0) ? vec_w_df - w_df_t'(term) : vec_w_df + w_df_t'(term);
      term = (dtheta * `FLL_B) >> `FLL_CONST_SHIFT;
      exp_w_df = (num < 0) ? exp_w_df - w_df_t'(term) : exp_w_df + w_df_t'(term);
      term = (dtheta * `FLL_A) >> `FLL_CONST_SHIFT;
      exp_w_df_dot = (num < 0) ? vec_w_df_dot - w_df_dot_t'(term) :
                                 vec_w_df_dot + w_df_dot_t'(term);
      w_mag = (exp_w_df < 0) ? -longint'(exp_w_df) : longint'(exp_w_df);
      term = (w_mag * `FLL_W_DF_TO_INC) >> `FLL_INC_SHIFT;
      exp_inc = (exp_w_df < 0) ? inc_t'(-term) : inc_t'(term);
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Checks and waits
   //////////////////////////////////////////////////////////////////////

   task automatic end_with_failure();
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic compare_w_df(input w_df_t got, input w_df_t exp, input string what);
      if (got !== exp) begin
         $display("error: time %0t: %s is %0d, expected %0d", $time, what, got, exp);
         end_with_failure();
      end
   endtask

   task automatic compare_w_df_dot(input w_df_dot_t got, input w_df_dot_t exp,
                                   input string what);
      if (got !== exp) begin
         $display("error: time %0t: %s is %0d, expected %0d", $time, what, got, exp);
         end_with_failure();
      end
   endtask

   task automatic compare_inc(input inc_t got, input inc_t exp, input string what);
      if (got !== exp) begin
         $display("error: time %0t: %s is %0d, expected %0d", $time, what, got, exp);
         end_with_failure();
      end
   endtask

   task automatic compare_tag(input tag_t got, input tag_t exp, input string what);
      if (got !== exp) begin
         $display("error: time %0t: %s is %0d, expected %0d", $time, what, got, exp);
         end_with_failure();
      end
   endtask

   task automatic set_vector(input acc_t i_k, input acc_t q_k, input acc_t i_km1,
                             input acc_t q_km1, input w_df_t w_df,
                             input w_df_dot_t w_df_dot);
      vec_i_k      = i_k;
      vec_q_k      = q_k;
      vec_i_km1    = i_km1;
      vec_q_km1    = q_km1;
      vec_iq_k     = magnitude_estimate(i_k, q_k);
      vec_iq_km1   = magnitude_estimate(i_km1, q_km1);
      vec_w_df     = w_df;
      vec_w_df_dot = w_df_dot;
   endtask

   // Inputs stay on the pins until the next start.
   task automatic drive_start(input tag_t tag);
      @(posedge clk);
      i_start         <= 1'b1;
      i_tag           <= tag;
      i_iq_prompt_k   <= vec_iq_k;
      i_iq_prompt_km1 <= vec_iq_km1;
      i_i_prompt_k    <= vec_i_k;
      i_q_prompt_k    <= vec_q_k;
      i_i_prompt_km1  <= vec_i_km1;
      i_q_prompt_km1  <= vec_q_km1;
      i_w_df_k        <= vec_w_df;
      i_w_df_dot_k    <= vec_w_df_dot;
      @(posedge clk);
      i_start <= 1'b0;
   endtask

   // Cycles are counted from the edge that drove i_start.
   task automatic wait_starting();
      bit seen;
      int cycles;
      seen = 1'b0;
      cycles = 0;
      while (!seen) begin
         @(negedge clk);
         cycles++;
         seen = o_starting;
         if (!seen && cycles >= WAIT_LIMIT) begin
            $display("Timed out waiting for o_starting after a start.");
            end_with_failure();
         end
      end
      if (cycles != `FLL_STARTING_DELAY) begin
         $display("error: time %0t: o_starting came %0d cycles after i_start, expected %0d",
                  $time, cycles, `FLL_STARTING_DELAY);
         end_with_failure();
      end
   endtask

   task automatic wait_result();
      bit seen;
      int cycles;
      seen = 1'b0;
      cycles = 0;
      while (!seen) begin
         @(negedge clk);
         cycles++;
         seen = o_result_ready;
         if (!seen && cycles >= WAIT_LIMIT) begin
            $display("Timed out waiting for o_result_ready.");
            end_with_failure();
         end
      end
   endtask

   task automatic check_result(input tag_t tag);
      w_df_t     exp_w_df;
      w_df_dot_t exp_w_df_dot;
      inc_t      exp_inc;
      model_update(exp_w_df, exp_w_df_dot, exp_inc);
      compare_w_df(o_w_df_kp1, exp_w_df, "o_w_df_kp1");
      compare_w_df_dot(o_w_df_dot_kp1, exp_w_df_dot, "o_w_df_dot_kp1");
      compare_inc(o_doppler_inc_kp1, exp_inc, "o_doppler_inc_kp1");
      compare_tag(o_result_tag, tag, "o_result_tag");
   endtask

   task automatic run_update(input tag_t tag);
      drive_start(tag);
      wait_starting();
      wait_result();
      check_result(tag);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////////////////////////

   task automatic test_reset_quiet();
      repeat (20) begin
         @(negedge clk);
         if (o_starting || o_result_ready) begin
            $display("o_starting or o_result_ready went high with no start after reset.");
            end_with_failure();
         end
      end
   endtask

   // Same vector twice gives a zero angle.
   task automatic test_zero_rotation();
      w_df_t per_only;
      set_vector(19'sd30000, -19'sd12000, 19'sd30000, -19'sd12000, 24'sd150000, 20'sd2000);
      run_update(6'd1);
      per_only = vec_w_df + w_df_t'((longint'(vec_w_df_dot) * `FLL_T) >> `FLL_PER_SHIFT);
      compare_w_df(o_w_df_kp1, per_only, "o_w_df_kp1 with zero angle");
      compare_w_df_dot(o_w_df_dot_kp1, vec_w_df_dot, "o_w_df_dot_kp1 with zero angle");
   endtask

   // Rotations by about 1/8 rad of a vector above 2^16.
   task automatic test_rotation();
      set_vector(19'sd57500, 19'sd27500, 19'sd60000, 19'sd20000, 24'sd12000, 20'sd750);
      run_update(6'd3);
      set_vector(19'sd62500, 19'sd12500, 19'sd60000, 19'sd20000, 24'sd12000, 20'sd750);
      run_update(6'd4);
   endtask

   task automatic test_negative_loop();
      set_vector(-19'sd19875, 19'sd44125, -19'sd25000, 19'sd41000,
                 -24'sd400000, -20'sd9000);
      run_update(6'd5);
      if (o_doppler_inc_kp1 >= 0) begin
         $display("Doppler increment is not negative for a negative frequency.");
         end_with_failure();
      end
   endtask

   task automatic test_random_cases();
      int        scale;
      acc_t      comp [4];
      tag_t      tag;
      w_df_t     w_df;
      w_df_dot_t w_df_dot;
      for (int n = 0; n < 20; n++) begin
         scale = 2 + int'(draw_bits(4)) % 15;
         for (int c = 0; c < 4; c++) begin
            comp[c] = acc_t'(draw_bits(16) & ((32'd1 << scale) - 1));
            if (draw_bits(1) == 32'd1) begin
               comp[c] = -comp[c];
            end
         end
         w_df     = w_df_t'(draw_bits(24));
         w_df_dot = w_df_dot_t'(draw_bits(20));
         tag      = tag_t'(draw_bits(6));
         set_vector(comp[0], comp[1], comp[2], comp[3], w_df, w_df_dot);
         run_update(tag);
      end
   endtask

   task automatic test_busy_start();
      set_vector(19'sd4000, -19'sd900, 19'sd3900, -19'sd1300, 24'sd70000, -20'sd1200);
      drive_start(6'd21);
      wait_starting();
      // Second strobe with another tag while the update runs.
      @(posedge clk);
      i_start <= 1'b1;
      i_tag   <= 6'd42;
      @(posedge clk);
      i_start <= 1'b0;
      wait_result();
      check_result(6'd21);
      repeat (60) begin
         @(negedge clk);
         if (o_result_ready) begin
            $display("A second result followed a start that came while busy.");
            end_with_failure();
         end
      end
   endtask

   initial begin
      reset           = 1'b1;
      i_start         = 1'b0;
      i_tag           = '0;
      i_iq_prompt_k   = '0;
      i_iq_prompt_km1 = '0;
      i_i_prompt_k    = '0;
      i_q_prompt_k    = '0;
      i_i_prompt_km1  = '0;
      i_q_prompt_km1  = '0;
      i_w_df_k        = '0;
      i_w_df_dot_k    = '0;
      lfsr_state      = 16'd91;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      test_reset_quiet();
      test_zero_rotation();
      test_rotation();
      test_negative_loop();
      test_random_cases();
      test_busy_start();
      $display("Test passed");
      $finish;
   end

endmodule
